// File: csr_bank.sv
// One bank of byte registers behind the quad-SPI slave.
// Registers 0..14 are read/write; the top register is a read-only count of
// accepted writes to this bank. Reads are registered one cycle after the strobe.

`timescale 1ns/1ps
`include "qspi_csr_defs.svh"

module csr_bank
    import qspi_csr_pkg::*;
#(
    parameter bank_idx_t bank_index = '0
) (
    input  logic      clk,
    input  logic      spi_reset_n,
    input  csr_req_t  csr_req,
    output csr_data_t rdata
);

    localparam int       RW_REGS = `CSR_REGS_PER_BANK - 1;
    localparam reg_idx_t CNT_REG = reg_idx_t'(RW_REGS);

    bank_idx_t req_bank;
    reg_idx_t  req_reg;
    logic      hit;
    logic      wr_hit;
    csr_data_t regs [RW_REGS];
    csr_data_t wr_count;

    assign req_bank = csr_req.addr[`QSPI_ADDR_W-1 -: $bits(bank_idx_t)];
    assign req_reg  = csr_req.addr[$bits(reg_idx_t)-1:0];
    assign hit      = (req_bank == bank_index);
    assign wr_hit   = csr_req.write && hit && (req_reg != CNT_REG);   // counter is read only

    // writable registers and the write counter
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            for (int i = 0; i < RW_REGS; i++) begin
                regs[i] <= '0;
            end
            wr_count <= '0;
        end else if (wr_hit) begin
            regs[req_reg] <= csr_req.wdata;
            wr_count      <= wr_count + 8'd1;     // wraps at 256
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            rdata <= '0;
        end else if (csr_req.read && hit) begin
            if (req_reg == CNT_REG) begin
                rdata <= wr_count;
            end else begin
                rdata <= regs[req_reg];
            end
        end
    end

endmodule

// File: csr_read_mux.sv
// Read data return path from the register banks to the quad-SPI slave.
// The addressed bank's byte is captured one cycle after that bank registers it
// and held for the slave's sdo shifter until the next read.

`timescale 1ns/1ps
`include "qspi_csr_defs.svh"

module csr_read_mux
    import qspi_csr_pkg::*;
(
    input  logic      clk,
    input  logic      spi_reset_n,
    input  csr_req_t  csr_req,
    input  csr_data_t bank_rdata [`CSR_BANK_COUNT],
    output csr_data_t csr_rdata
);

    logic      rd_q;       // read strobe, aligned with bank rdata
    bank_idx_t bank_q;

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= csr_req.read;
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= csr_req.addr[`QSPI_ADDR_W-1 -: $bits(bank_idx_t)];
    end

    // holding register, only moves on a read
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            csr_rdata <= '0;
        end else if (rd_q) begin
            csr_rdata <= bank_rdata[bank_q];
        end
    end

endmodule

// File: qspi_csr_defs.svh
// Sizing macros for the quad-SPI register file subsystem.
// Included by the package and by every module that needs a width or count.

`ifndef QSPI_CSR_DEFS_SVH
`define QSPI_CSR_DEFS_SVH

// register address carried in the command byte, upper bits pick the bank
`define QSPI_ADDR_W 6

// identical register banks behind the slave
`define CSR_BANK_COUNT 4

// byte registers in one bank, the last one is the write counter
`define CSR_REGS_PER_BANK 16

// flops between nss and the clk domain
`define QSPI_SYNC_STAGES 2

`endif

// File: qspi_csr_pkg.sv
// Shared types for the quad-SPI register file subsystem.
// Modules pull these in with a wildcard import in their header.

`include "qspi_csr_defs.svh"

package qspi_csr_pkg;

    // full register address, {bank, reg}
    typedef logic [`QSPI_ADDR_W-1:0] csr_addr_t;

    typedef logic [$clog2(`CSR_BANK_COUNT)-1:0] bank_idx_t;     // bank number
    typedef logic [$clog2(`CSR_REGS_PER_BANK)-1:0] reg_idx_t;   // register inside a bank

    typedef logic [7:0] csr_data_t;                             // register contents

    // position inside a host frame, counted in bytes on the sck side
    typedef enum logic [1:0] {
        PH_CMD,     // command byte being shifted in
        PH_TURN,    // write data or read turnaround byte
        PH_DATA,    // read data byte going out on sdo
        PH_DONE     // anything after that is ignored
    } frame_phase_t;

    // single-cycle request from the slave to the banks and the read mux
    typedef struct packed {
        logic      read;
        logic      write;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

endpackage

// File: qspi_csr_top.sv
// Top level of the quad-SPI register file. The slave turns host frames into
// requests for the banks; the read mux returns the addressed byte for sdo.
// Pins: clk, spi_reset_n, sck, nss, sdi, sdo, sdo_en.

`timescale 1ns/1ps
`include "qspi_csr_defs.svh"

module qspi_csr_top
    import qspi_csr_pkg::*;
(
    input  logic       clk,
    input  logic       spi_reset_n,
    input  logic       sck,
    input  logic       nss,
    input  logic [3:0] sdi,
    output logic [3:0] sdo,
    output logic       sdo_en
);

    csr_req_t  csr_req;
    csr_data_t csr_rdata;
    csr_data_t bank_rdata [`CSR_BANK_COUNT];

    qspi_slave qspi_slave_inst (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .sck         (sck),
        .nss         (nss),
        .sdi         (sdi),
        .sdo         (sdo),
        .sdo_en      (sdo_en),
        .csr_rdata   (csr_rdata),
        .csr_req     (csr_req)
    );

    for (genvar i = 0; i < `CSR_BANK_COUNT; i++) begin : g_bank
        csr_bank #(
            .bank_index (bank_idx_t'(i))
        ) csr_bank_inst (
            .clk         (clk),
            .spi_reset_n (spi_reset_n),
            .csr_req     (csr_req),
            .rdata       (bank_rdata[i])
        );
    end

    csr_read_mux csr_read_mux_inst (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .csr_req     (csr_req),
        .bank_rdata  (bank_rdata),
        .csr_rdata   (csr_rdata)
    );

endmodule

// File: qspi_slave.sv
// Quad-SPI slave front end. The host clocks in a command byte, then either
// a data byte (write) or a turnaround byte followed by a read byte on sdo.
// Every completed frame becomes one single-cycle request on csr_req in the
// clk domain. The host must keep each sck half period at 6+ clk cycles.

`timescale 1ns/1ps
`include "qspi_csr_defs.svh"

module qspi_slave
    import qspi_csr_pkg::*;
(
    input  logic       clk,
    input  logic       spi_reset_n,
    input  logic       sck,
    input  logic       nss,
    input  logic [3:0] sdi,
    output logic [3:0] sdo,
    output logic       sdo_en,
    input  csr_data_t  csr_rdata,
    output csr_req_t   csr_req
);

    logic         session_rst_n;    // low outside a frame
    logic [3:0]   rx_nib;           // first nibble of the byte in flight
    logic         nib_toggle;       // 1 when the next rising edge ends a byte
    frame_phase_t phase;
    logic         is_write;
    csr_addr_t    addr_sck;
    csr_data_t    wdata_sck;
    logic         byte1_done;       // level event, held until nss rises
    csr_data_t    treg;             // sdo shifter
    logic         sdo_oe;

    logic [`QSPI_SYNC_STAGES-1:0] nss_sync;
    logic [2:0]   evt_sync;
    logic         frame_on;
    logic         evt_rise;
    logic         cap_en;
    csr_addr_t    addr_q;
    csr_data_t    wdata_d0;
    csr_data_t    wdata_q;
    logic         rd_q;
    logic         wr_arm;
    logic         wr_q;

    assign session_rst_n = spi_reset_n & ~nss;

    // receive side, one nibble per rising edge, msn first
    always_ff @(posedge sck or negedge session_rst_n) begin
        if (!session_rst_n) begin
            rx_nib     <= '0;
            nib_toggle <= 1'b0;
            phase      <= PH_CMD;
            is_write   <= 1'b0;
            addr_sck   <= '0;
            wdata_sck  <= '0;
            byte1_done <= 1'b0;
        end else begin
            nib_toggle <= ~nib_toggle;
            if (!nib_toggle) begin
                rx_nib <= sdi;
            end else begin
                case (phase)
                    PH_CMD: begin
                        is_write <= rx_nib[3];                          // bit 6 is ignored
                        addr_sck <= {rx_nib[`QSPI_ADDR_W-5:0], sdi};
                        phase    <= PH_TURN;
                    end
                    PH_TURN: begin
                        wdata_sck  <= {rx_nib, sdi};                    // junk on a read
                        byte1_done <= 1'b1;
                        phase      <= PH_DATA;
                    end
                    PH_DATA: phase <= PH_DONE;
                    PH_DONE: ;                                          // burst bytes dropped
                endcase
            end
        end
    end

    // transmit side works on the falling edge so the host samples mid-bit
    always_ff @(negedge sck or negedge session_rst_n) begin
        if (!session_rst_n) begin
            treg   <= '0;
            sdo_oe <= 1'b0;
        end else begin
            if (phase == PH_DATA && !is_write) begin
                sdo_oe <= 1'b1;                     // first fall after the turnaround
            end
            if (!nib_toggle) begin
                treg <= csr_rdata;                  // byte boundary
            end else begin
                treg <= {treg[3:0], 4'h0};
            end
        end
    end

    assign sdo    = treg[7:4];
    assign sdo_en = sdo_oe;

    // clk side synchronisers
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            nss_sync <= '1;                         // bus idles deselected
            evt_sync <= '0;
        end else begin
            nss_sync <= {nss_sync[`QSPI_SYNC_STAGES-2:0], nss};
            evt_sync <= {evt_sync[1:0], byte1_done};
        end
    end

    assign frame_on = ~nss_sync[`QSPI_SYNC_STAGES-1];
    assign evt_rise = evt_sync[1] & ~evt_sync[2] & frame_on;
    assign cap_en   = ~evt_sync[1] & frame_on;       // sck-side fields still settling

    // addr and the first wdata stage track the sck registers until the event lands,
    // so both are a full cycle old by the time evt_rise is seen
    always_ff @(posedge clk) begin
        if (cap_en) begin
            addr_q   <= addr_sck;
            wdata_d0 <= wdata_sck;
        end
        if (evt_rise) begin
            wdata_q <= wdata_d0;
        end
    end

    // read goes out with the rising event, write one cycle behind it
    // once wdata_q has settled; is_write has been static for a whole byte here
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            rd_q   <= 1'b0;
            wr_arm <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            rd_q   <= evt_rise & ~is_write;
            wr_arm <= evt_rise & is_write;
            wr_q   <= wr_arm;
        end
    end

    assign csr_req.read  = rd_q;
    assign csr_req.write = wr_q;
    assign csr_req.addr  = addr_q;
    assign csr_req.wdata = wdata_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -j 0 --top-module tb_qspi_csr_top -f tb.f -o tb_sim \
    > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Checks failed" "$sim_log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: tb.f
+incdir+.
qspi_csr_pkg.sv
qspi_slave.sv
csr_bank.sv
csr_read_mux.sv
qspi_csr_top.sv
tb_qspi_csr_top.sv

// File: tb_qspi_csr_top.sv
// Directed testbench for the quad-SPI register file.
// A host model sends frames on sck/nss/sdi and samples sdo. A reference array
// tracks the expected register and counter contents for every read.
// Run through tb.f with the testbench as top module.

`timescale 1ns/1ps
`include "qspi_csr_defs.svh"

module tb_qspi_csr_top
    import qspi_csr_pkg::*;
();

    localparam int          CLK_HALF_NS     = 2;            // 4 ns clk
    localparam int          RESET_CYCLES    = 8;
    localparam int          SCK_HALF        = 8;            // clk cycles per sck half period
    localparam int          FRAME_GAP       = 8;            // idle clk cycles with nss high
    localparam int          SDO_EN_TIMEOUT  = 16;
    localparam int          WATCHDOG_CYCLES = 200000;
    localparam int          RANDOM_OPS      = 200;
    localparam logic [31:0] RAND_SEED       = 32'h4317_130b;
    localparam int          NUM_REGS        = `CSR_BANK_COUNT * `CSR_REGS_PER_BANK;

    logic       clk = 1'b0;
    logic       spi_reset_n;
    logic       sck;
    logic       nss;
    logic [3:0] sdi;
    logic [3:0] sdo;
    logic       sdo_en;

    csr_data_t  ref_regs [NUM_REGS];    // expected register file, counters included

    always #(CLK_HALF_NS) clk = ~clk;

    qspi_csr_top qspi_csr_top_inst (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .sck         (sck),
        .nss         (nss),
        .sdi         (sdi),
        .sdo         (sdo),
        .sdo_en      (sdo_en)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_data(input string name, input csr_data_t expected,
                              input csr_data_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch in %s: expected 8'h%h, actual 8'h%h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch in %s: expected sdo_en %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    task automatic wait_clk(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
    endtask

    // sdo_en should already be up after the turnaround byte
    task automatic wait_sdo_en(input string name);
        int waited;
        waited = 0;
        while (sdo_en !== 1'b1 && waited < SDO_EN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (sdo_en !== 1'b1) begin
            stop_with_failure({name, ": sdo_en never rose after the turnaround byte"});
        end
    endtask

    // one sck period, sdo is sampled just before the rising edge
    task automatic shift_nibble(input logic [3:0] nib, output logic [3:0] sdo_seen,
                                output logic en_seen);
        sdi = nib;
        wait_clk(SCK_HALF);
        sdo_seen = sdo;
        en_seen  = sdo_en;
        sck      = 1'b1;
        wait_clk(SCK_HALF);
        sck      = 1'b0;
    endtask

    task automatic send_byte(input csr_data_t value);
        logic [3:0] unused_nib;
        logic       unused_en;
        shift_nibble(value[7:4], unused_nib, unused_en);    // msn first
        shift_nibble(value[3:0], unused_nib, unused_en);
    endtask

    task automatic begin_frame();
        nss = 1'b0;
        wait_clk(SCK_HALF);
    endtask

    task automatic end_frame();
        wait_clk(2);
        nss = 1'b1;
        sdi = 4'h0;
        wait_clk(FRAME_GAP);
    endtask

    // expected effect of an accepted write
    function automatic void model_write(input csr_addr_t addr, input csr_data_t data);
        bank_idx_t bank;
        reg_idx_t  reg_n;
        csr_addr_t cnt_addr;
        {bank, reg_n} = addr;
        cnt_addr = {bank, reg_idx_t'(`CSR_REGS_PER_BANK - 1)};
        if (reg_n != reg_idx_t'(`CSR_REGS_PER_BANK - 1)) begin
            ref_regs[addr]     = data;
            ref_regs[cnt_addr] = ref_regs[cnt_addr] + 8'd1;
        end
    endfunction

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data, input logic bit6);
        begin_frame();
        send_byte({1'b1, bit6, addr});
        send_byte(data);
        end_frame();
        model_write(addr, data);
    endtask

    task automatic read_reg(input string name, input csr_addr_t addr, input logic bit6,
                            output csr_data_t data);
        logic [3:0] nib_hi;
        logic [3:0] nib_lo;
        logic       en_hi;
        logic       en_lo;
        begin_frame();
        send_byte({1'b0, bit6, addr});
        shift_nibble(4'h0, nib_hi, en_hi);                  // turnaround byte
        shift_nibble(4'h0, nib_lo, en_lo);
        check_bit(name, 1'b0, en_lo);                       // not driven before data byte
        wait_sdo_en(name);
        shift_nibble(4'h0, nib_hi, en_hi);
        shift_nibble(4'h0, nib_lo, en_lo);
        check_bit(name, 1'b1, en_hi);
        check_bit(name, 1'b1, en_lo);
        data = {nib_hi, nib_lo};
        end_frame();
        check_bit(name, 1'b0, sdo_en);                      // released with nss high
    endtask

    task automatic reset_idle();
        csr_data_t got;
        check_bit("reset_idle", 1'b0, sdo_en);
        for (int a = 0; a < NUM_REGS; a++) begin
            read_reg("reset_idle", csr_addr_t'(a), 1'b0, got);
            check_data("reset_idle", 8'h00, got);           // data and counters clear
        end
    endtask

    task automatic write_readback();
        csr_data_t got;
        write_reg(6'h05, 8'hA5, 1'b0);
        read_reg("write_readback", 6'h05, 1'b0, got);
        check_data("write_readback", 8'hA5, got);
    endtask

    task automatic bank_isolation();
        csr_addr_t addr;
        csr_data_t got;
        for (int b = 0; b < `CSR_BANK_COUNT; b++) begin
            addr = {bank_idx_t'(b), reg_idx_t'(3)};
            write_reg(addr, csr_data_t'(8'h11 * (b + 1)), 1'b0);
        end
        for (int b = 0; b < `CSR_BANK_COUNT; b++) begin
            addr = {bank_idx_t'(b), reg_idx_t'(3)};
            read_reg("bank_isolation", addr, 1'b0, got);
            check_data("bank_isolation", csr_data_t'(8'h11 * (b + 1)), got);
        end
    endtask

    task automatic write_counter();
        csr_data_t start_cnt;
        csr_data_t expected_cnt;
        csr_data_t got;
        read_reg("write_counter", 6'h2F, 1'b0, start_cnt);
        check_data("write_counter", ref_regs[6'h2F], start_cnt);
        expected_cnt = ref_regs[6'h2F] + 8'd4;              // four of the five writes count
        write_reg(6'h20, 8'h01, 1'b0);
        write_reg(6'h21, 8'h02, 1'b1);
        write_reg(6'h2F, 8'hFF, 1'b0);                      // counter itself, must be ignored
        write_reg(6'h22, 8'h03, 1'b0);
        write_reg(6'h2E, 8'h7E, 1'b0);
        read_reg("write_counter", 6'h2F, 1'b0, got);
        check_data("write_counter", expected_cnt, got);
        read_reg("write_counter", 6'h2E, 1'b0, got);
        check_data("write_counter", 8'h7E, got);
    endtask

    task automatic aborted_frame();
        logic [3:0] unused_nib;
        logic       unused_en;
        csr_data_t  got;
        write_reg(6'h27, 8'h5C, 1'b0);
        begin_frame();                                      // command byte only
        send_byte({1'b1, 1'b0, 6'h27});
        end_frame();
        begin_frame();                                      // cut inside the data byte
        send_byte({1'b1, 1'b0, 6'h27});
        shift_nibble(4'hE, unused_nib, unused_en);
        end_frame();
        read_reg("aborted_frame", 6'h27, 1'b0, got);
        check_data("aborted_frame", 8'h5C, got);
        read_reg("aborted_frame", 6'h2F, 1'b0, got);
        check_data("aborted_frame", ref_regs[6'h2F], got);
    endtask

    task automatic random_traffic();
        logic [31:0] rnd;
        csr_addr_t   addr;
        csr_data_t   got;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd  = $urandom();
            addr = rnd[5:0];
            if (rnd[16]) begin
                write_reg(addr, rnd[15:8], rnd[17]);
            end else begin
                read_reg("random_traffic", addr, rnd[17], got);
                check_data("random_traffic", ref_regs[addr], got);
            end
        end
    endtask

    // watchdog
    initial begin
        wait_clk(WATCHDOG_CYCLES);
        stop_with_failure("timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        void'($urandom(RAND_SEED));
        spi_reset_n = 1'b0;
        sck         = 1'b0;
        nss         = 1'b1;
        sdi         = 4'h0;
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        wait_clk(RESET_CYCLES);
        spi_reset_n = 1'b1;
        wait_clk(FRAME_GAP);

        reset_idle();
        write_readback();
        bank_isolation();
        write_counter();
        aborted_frame();
        random_traffic();

        $display("All checks passed");
        $finish;
    end

endmodule
